// File: sim.f
+incdir+logic
logic/mand_pkg.sv
logic/mand_mult.sv
logic/mand_addsub.sv
logic/mand_ctx_shift.sv
logic/mand_pipe.sv
logic/mand_engine.sv
logic/mand_wb_regs.sv
logic/mand_top.sv
dv/mand_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module mand_tb -o mand_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/mand_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

// File: dv/mand_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "mand_macros.svh"

module mand_tb
  import mand_pkg::*;
();

  localparam int BUS_TIMEOUT = 16;
  localparam mand_fix_t ONE = 32'sh0100_0000;

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic        wb_ack;
  logic [31:0] wb_dat_r;

  logic [31:0] lfsr_q;
  mand_iter_t  exp_iter [256];
  logic        pending [256];   // tag pushed and not yet seen
  logic [31:0] got_q [$];       // popped result words for the checker
  mand_iter_t  limit_now;
  int          sent;
  int          got;
  int          checks;
  int          test_err;
  int          total_err;
  int          tests_run;
  int          tests_failed;

  mand_top u_dut (
    .clk_i    (clk),
    .rst_i    (rst),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_ack_o (wb_ack),
    .wb_dat_o (wb_dat_r)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Q8.24 product as the low word of the shifted 64-bit product
  function automatic mand_fix_t fix_mul(input mand_fix_t a, input mand_fix_t b);
    logic [63:0] p;
    p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    return p[55:24];
  endfunction

  function automatic mand_iter_t iterate_ref(input mand_fix_t c_re, input mand_fix_t c_im,
                                             input mand_iter_t max_it);
    mand_fix_t  x;
    mand_fix_t  y;
    mand_fix_t  xn;
    mand_fix_t  yn;
    mand_fix_t  mag;
    mand_iter_t it;
    x = '0;
    y = '0;
    it = '0;
    for (int n = 0; n < 256; n++)
    begin
      xn = c_re + (fix_mul(x, x) - fix_mul(y, y));
      yn = c_im + (fix_mul(x, y) + fix_mul(x, y));   // 2xy as a doubled sum
      mag = fix_mul(xn, xn) + fix_mul(yn, yn);
      it = it + 8'd1;
      if ((mag > `MAND_ESCAPE) || (it == max_it))
        return it;
      x = xn;
      y = yn;
    end
    return it;
  endfunction

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[30:0], lfsr_q[31]};
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
    end
    return r;
  endfunction

  // 26 bits span 0 to 4.0 and are shifted down to -2.0 .. +2.0
  function automatic mand_fix_t random_c();
    return mand_fix_t'(random_bits(26) - 32'h0200_0000);
  endfunction

  task automatic note_error();
    test_err++;
    total_err++;
  endtask

  task automatic check_value(input string name, input logic [31:0] got_v,
                             input logic [31:0] exp_v);
    checks++;
    if (got_v !== exp_v)
    begin
      $display("Fail at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got_v, exp_v);
      note_error();
    end
  endtask

  task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    int n;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdat;
    n = 0;
    @(negedge clk);
    while (!wb_ack && n < BUS_TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (!wb_ack)
    begin
      $display("bus slave gave no ack at address %0d within %0d cycles", adr, BUS_TIMEOUT);
      $display("Some tests failed");
      $finish;
    end
    else
    begin
      rdat = wb_dat_r;
      checks++;
      if (n != 0)
      begin
        $display("bus slave gave ack %0d cycles late at address %0d", n, adr);
        note_error();
      end
      @(negedge clk);   // held through the ack cycle
      checks++;
      if (wb_ack)
      begin
        $display("bus slave held ack for more than one cycle at address %0d", adr);
        note_error();
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
    end
  endtask

  task automatic bus_write(input logic [2:0] adr, input logic [31:0] dat);
    logic [31:0] unused_rd;
    bus_access(1'b1, adr, dat, unused_rd);
  endtask

  task automatic bus_read(input logic [2:0] adr, output logic [31:0] dat);
    bus_access(1'b0, adr, 32'd0, dat);
  endtask

  task automatic push_job(input mand_tag_t tag, input mand_fix_t cre, input mand_fix_t cim,
                          input bit expect_result);
    bus_write(`MAND_ADDR_CRE, cre);
    bus_write(`MAND_ADDR_CIM, cim);
    bus_write(`MAND_ADDR_PUSH, {24'd0, tag});
    if (expect_result)
    begin
      exp_iter[tag] = iterate_ref(cre, cim, limit_now);
      pending[tag] = 1'b1;
      sent++;
    end
  endtask

  task automatic pop_one();
    logic [31:0] w;
    bus_read(`MAND_ADDR_RESULT, w);
    if (w[31])
    begin
      got_q.push_back(w);
      got++;
    end
  endtask

  // pushes while STATUS shows room and tags each job with the sent count
  task automatic push_points(input int n, input bit pop_when_full, input bit zero_c);
    logic [31:0] st;
    mand_fix_t   cre;
    mand_fix_t   cim;
    int          guard;
    guard = 0;
    while (sent < n && guard < 2000)
    begin
      bus_read(`MAND_ADDR_STATUS, st);
      if (st[3:0] != 4'd0)
      begin
        cre = zero_c ? '0 : random_c();
        cim = zero_c ? '0 : random_c();
        push_job(mand_tag_t'(sent), cre, cim, 1'b1);
      end
      else if (pop_when_full)
        pop_one();
      guard++;
    end
    if (sent < n)
    begin
      $display("job queue never had room, %0d of %0d jobs pushed", sent, n);
      note_error();
    end
  endtask

  task automatic drain_results();
    logic [31:0] w;
    int          guard;
    guard = 0;
    while (got < sent && guard < 30000)
    begin
      pop_one();
      guard++;
    end
    if (got < sent)
    begin
      $display("results missing, %0d of %0d came back", got, sent);
      note_error();
    end
    guard = 0;
    while (got_q.size() != 0 && guard < 10)
    begin
      @(negedge clk);
      guard++;
    end
    if (got_q.size() != 0)
    begin
      $display("result checker left %0d popped results unchecked", got_q.size());
      note_error();
    end
    // a few loop periods more so that a stray result would show up
    repeat (3 * 5 * `MAND_STAGE_LAT) @(negedge clk);
    bus_read(`MAND_ADDR_RESULT, w);
    check_value("RESULT after drain", w, 32'd0);
  endtask

  task automatic start_test();
    test_err = 0;
    sent = 0;
    got = 0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_err == 0)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      $display("test %0d %s: %0d errors", tests_run, name, test_err);
      tests_failed++;
    end
  endtask

  initial
  begin : result_checker
    logic [31:0] w;
    mand_tag_t   tag;
    mand_iter_t  it;
    forever
    begin
      @(posedge clk);
      while (got_q.size() > 0)
      begin
        w = got_q.pop_front();
        tag = w[15:8];
        it = w[7:0];
        checks++;
        if (!pending[tag])
        begin
          $display("result for tag %0d was never pushed or came back twice", tag);
          note_error();
        end
        else if (it !== exp_iter[tag])
        begin
          $display("Fail at %0t ns: wb_dat_o[7:0] for tag %0d is %0d, expected %0d",
                   $time, tag, it, exp_iter[tag]);
          note_error();
        end
        if (it > limit_now)
        begin
          $display("count %0d of tag %0d is above the limit %0d", it, tag, limit_now);
          note_error();
        end
        pending[tag] = 1'b0;
      end
    end
  end

  initial
  begin : stimulus
    logic [31:0] rd;
    int          guard;
    lfsr_q = 32'ha885;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 3'd0;
    wb_dat_w = 32'd0;
    limit_now = 8'd32;
    checks = 0;
    total_err = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int i = 0; i < 256; i++)
    begin
      pending[i] = 1'b0;
      exp_iter[i] = '0;
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;

    start_test();
    bus_read(`MAND_ADDR_STATUS, rd);
    check_value("STATUS free space", {28'd0, rd[3:0]}, 32'd4);
    check_value("STATUS result count", {28'd0, rd[11:8]}, 32'd0);
    check_value("STATUS overflow", {31'd0, rd[16]}, 32'd0);
    bus_read(`MAND_ADDR_MAXIT, rd);
    check_value("MAXIT", rd, 32'd32);
    bus_read(`MAND_ADDR_RESULT, rd);
    check_value("RESULT on empty queue", rd, 32'd0);
    end_test("reset state");

    start_test();
    push_job(8'd0, '0, '0, 1'b1);
    push_job(8'd1, ONE, ONE, 1'b1);
    push_job(8'd2, -ONE, '0, 1'b1);
    check_value("expected count for c = 0", {24'd0, exp_iter[0]}, 32'd32);
    check_value("expected count for c = 1+1i", {24'd0, exp_iter[1]}, 32'd2);
    check_value("expected count for c = -1", {24'd0, exp_iter[2]}, 32'd32);
    drain_results();
    end_test("known points");

    start_test();
    push_points(40, 1'b1, 1'b0);
    drain_results();
    end_test("random points");

    start_test();
    bus_write(`MAND_ADDR_MAXIT, 32'd5);
    limit_now = 8'd5;
    bus_read(`MAND_ADDR_MAXIT, rd);
    check_value("MAXIT", rd, 32'd5);
    push_job(8'd0, '0, '0, 1'b1);
    push_job(8'd1, ONE, ONE, 1'b1);
    push_job(8'd2, -ONE, '0, 1'b1);
    push_points(15, 1'b1, 1'b0);
    drain_results();
    end_test("iteration limit 5");

    start_test();
    bus_write(`MAND_ADDR_MAXIT, 32'd32);
    limit_now = 8'd32;
    push_points(20, 1'b0, 1'b0);
    guard = 0;
    rd = '0;
    while (rd[11:8] != 4'd8 && guard < 1000)
    begin
      bus_read(`MAND_ADDR_STATUS, rd);
      guard++;
    end
    check_value("STATUS result count with result queue full", {28'd0, rd[11:8]}, 32'd8);
    drain_results();
    end_test("result back-pressure");

    // c = 0 with limit 40 keeps every slot busy for 800 cycles
    start_test();
    bus_write(`MAND_ADDR_MAXIT, 32'd40);
    limit_now = 8'd40;
    push_points(24, 1'b0, 1'b1);
    bus_read(`MAND_ADDR_STATUS, rd);
    check_value("STATUS free space before burst", {28'd0, rd[3:0]}, 32'd0);
    for (int i = 24; i < 29; i++)
      push_job(mand_tag_t'(i), '0, '0, 1'b0);
    bus_read(`MAND_ADDR_STATUS, rd);
    check_value("STATUS overflow", {31'd0, rd[16]}, 32'd1);
    drain_results();
    end_test("job queue overflow");

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_err);
    if (total_err == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/mand_top.sv
`timescale 1ns/1ns
`default_nettype none

module mand_top
  import mand_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        wb_cyc_i,
  input  wire logic        wb_stb_i,
  input  wire logic        wb_we_i,
  input  wire logic [2:0]  wb_adr_i,
  input  wire logic [31:0] wb_dat_i,
  output logic             wb_ack_o,
  output logic [31:0]      wb_dat_o
);

  logic       job_valid;
  mand_job_t  job;
  logic       job_take;
  logic       res_push;
  mand_res_t  res;
  logic       res_full;
  mand_iter_t max_iter;
  mand_fix_t  xn;
  mand_fix_t  yn;
  mand_fix_t  xnext;
  mand_fix_t  ynext;
  mand_fix_t  result;
  mand_ctx_t  load;
  mand_ctx_t  store;

  mand_wb_regs u_regs (
    .clk_i, .rst_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_ack_o, .wb_dat_o,
    .job_valid_o (job_valid), .job_o (job), .job_take_i (job_take),
    .res_push_i (res_push), .res_i (res), .res_full_o (res_full),
    .max_iter_o (max_iter)
  );

  mand_engine u_engine (
    .job_valid_i (job_valid), .job_i (job), .job_take_o (job_take),
    .max_iter_i (max_iter), .res_full_i (res_full), .res_push_o (res_push), .res_o (res),
    .xnext_i (xnext), .ynext_i (ynext), .store_i (store), .result_i (result),
    .xn_o (xn), .yn_o (yn), .load_o (load)
  );

  mand_pipe u_pipe (
    .clk_i, .rst_i,
    .xn_i (xn), .yn_i (yn), .load_i (load),
    .xnext_o (xnext), .ynext_o (ynext), .store_o (store), .result_o (result)
  );

endmodule

`default_nettype wire

// File: logic/mand_wb_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "mand_macros.svh"

module mand_wb_regs
  import mand_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        wb_cyc_i,
  input  wire logic        wb_stb_i,
  input  wire logic        wb_we_i,
  input  wire logic [2:0]  wb_adr_i,
  input  wire logic [31:0] wb_dat_i,
  output logic             wb_ack_o,
  output logic [31:0]      wb_dat_o,
  output logic             job_valid_o,
  output mand_job_t        job_o,
  input  wire logic        job_take_i,
  input  wire logic        res_push_i,
  input  wire mand_res_t   res_i,
  output logic             res_full_o,
  output mand_iter_t       max_iter_o
);

  localparam int JQ_DEPTH = `MAND_JOBQ_DEPTH;
  localparam int RQ_DEPTH = `MAND_RESQ_DEPTH;
  localparam int JQ_AW    = $clog2(JQ_DEPTH);
  localparam int RQ_AW    = $clog2(RQ_DEPTH);
  localparam logic [JQ_AW:0] JQ_FULL = JQ_DEPTH[JQ_AW:0];
  localparam logic [RQ_AW:0] RQ_FULL = RQ_DEPTH[RQ_AW:0];

  logic             wr_cyc;    // write in its ack cycle
  logic             job_req;
  logic             job_push;
  logic             rd_pop;
  mand_fix_t        cre_q;
  mand_fix_t        cim_q;
  mand_iter_t       maxit_q;
  logic             ovf_q;
  mand_job_t        jq_mem [JQ_DEPTH];
  logic [JQ_AW-1:0] jq_wr_q;
  logic [JQ_AW-1:0] jq_rd_q;
  logic [JQ_AW:0]   jq_cnt_q;
  mand_res_t        rq_mem [RQ_DEPTH];
  logic [RQ_AW-1:0] rq_wr_q;
  logic [RQ_AW-1:0] rq_rd_q;
  logic [RQ_AW:0]   rq_cnt_q;

  assign wr_cyc   = wb_cyc_i && wb_stb_i && wb_ack_o && wb_we_i;
  assign job_req  = wr_cyc && (wb_adr_i == `MAND_ADDR_PUSH);
  assign job_push = job_req && (jq_cnt_q != JQ_FULL);
  assign rd_pop   = wb_cyc_i && wb_stb_i && wb_ack_o && !wb_we_i &&
                    (wb_adr_i == `MAND_ADDR_RESULT) && (rq_cnt_q != '0);

  assign job_valid_o = (jq_cnt_q != '0);
  assign job_o       = jq_mem[jq_rd_q];
  assign res_full_o  = (rq_cnt_q == RQ_FULL);
  assign max_iter_o  = maxit_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wb_ack_o <= 1'b0;
      maxit_q  <= 8'd32;
      ovf_q    <= 1'b0;
      jq_wr_q  <= '0;
      jq_rd_q  <= '0;
      jq_cnt_q <= '0;
      rq_wr_q  <= '0;
      rq_rd_q  <= '0;
      rq_cnt_q <= '0;
    end
    else
    begin
      wb_ack_o <= wb_cyc_i && wb_stb_i && !wb_ack_o;  // single cycle ack without wait states
      if (wr_cyc && (wb_adr_i == `MAND_ADDR_MAXIT))
        maxit_q <= wb_dat_i[7:0];
      if (job_req && !job_push)
        ovf_q <= 1'b1;          // sticky
      if (job_push)
        jq_wr_q <= jq_wr_q + JQ_AW'(1);
      if (job_take_i)
        jq_rd_q <= jq_rd_q + JQ_AW'(1);
      jq_cnt_q <= jq_cnt_q + {{JQ_AW{1'b0}}, job_push} - {{JQ_AW{1'b0}}, job_take_i};
      if (res_push_i)
        rq_wr_q <= rq_wr_q + RQ_AW'(1);
      if (rd_pop)
        rq_rd_q <= rq_rd_q + RQ_AW'(1);
      rq_cnt_q <= rq_cnt_q + {{RQ_AW{1'b0}}, res_push_i} - {{RQ_AW{1'b0}}, rd_pop};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_cyc && (wb_adr_i == `MAND_ADDR_CRE))
      cre_q <= wb_dat_i;
    if (wr_cyc && (wb_adr_i == `MAND_ADDR_CIM))
      cim_q <= wb_dat_i;
    if (job_push)
      jq_mem[jq_wr_q] <= '{tag: wb_dat_i[7:0], c_re: cre_q, c_im: cim_q};
    if (res_push_i)
      rq_mem[rq_wr_q] <= res_i;
  end

  always_comb
  begin
    wb_dat_o = '0;
    case (wb_adr_i)
      `MAND_ADDR_CRE:    wb_dat_o = cre_q;
      `MAND_ADDR_CIM:    wb_dat_o = cim_q;
      `MAND_ADDR_MAXIT:  wb_dat_o = {24'd0, maxit_q};
      `MAND_ADDR_STATUS: wb_dat_o = {15'd0, ovf_q, 4'd0, 4'(rq_cnt_q), 4'd0,
                                     4'(JQ_FULL - jq_cnt_q)};
      `MAND_ADDR_RESULT:
      begin
        if (rq_cnt_q != '0)
          wb_dat_o = {1'b1, 15'd0, rq_mem[rq_rd_q]};  // empty queue reads as 0
      end
      default:           wb_dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/mand_engine.sv
`timescale 1ns/1ns
`default_nettype none
`include "mand_macros.svh"

module mand_engine
  import mand_pkg::*;
(
  input  wire logic       job_valid_i,
  input  wire mand_job_t  job_i,
  output logic            job_take_o,
  input  wire mand_iter_t max_iter_i,
  input  wire logic       res_full_i,
  output logic            res_push_o,
  output mand_res_t       res_o,
  input  wire mand_fix_t  xnext_i,
  input  wire mand_fix_t  ynext_i,
  input  wire mand_ctx_t  store_i,
  input  wire mand_fix_t  result_i,
  output mand_fix_t       xn_o,
  output mand_fix_t       yn_o,
  output mand_ctx_t       load_o
);

  mand_iter_t iter_inc;
  mand_iter_t iter_out;
  logic       escaped;
  logic       finished;
  logic       slot_free;

  assign iter_inc = store_i.iter + 8'd1;
  assign escaped  = result_i > mand_fix_t'(`MAND_ESCAPE);  // signed compare
  assign finished = store_i.done || escaped || (iter_inc == max_iter_i);

  // a parked item already holds its final count
  assign iter_out = store_i.done ? store_i.iter : iter_inc;

  assign res_o      = '{tag: store_i.tag, iter: iter_out};
  assign res_push_o = store_i.valid && finished && !res_full_i;
  assign slot_free  = !store_i.valid || res_push_o;
  assign job_take_o = slot_free && job_valid_i;

  always_comb
  begin
    load_o = '0;
    xn_o   = '0;
    yn_o   = '0;
    if (!slot_free)
    begin
      // recirculate, parking finished items with done set
      load_o      = store_i;
      load_o.done = finished;
      load_o.iter = iter_out;
      xn_o        = xnext_i;
      yn_o        = ynext_i;
    end
    else if (job_valid_i)
    begin
      load_o.valid = 1'b1;   // new job starts at z = 0
      load_o.tag   = job_i.tag;
      load_o.c_re  = job_i.c_re;
      load_o.c_im  = job_i.c_im;
    end
  end

endmodule

`default_nettype wire

// File: logic/mand_pipe.sv
`timescale 1ns/1ns
`default_nettype none
`include "mand_macros.svh"

module mand_pipe
  import mand_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire mand_fix_t xn_i,
  input  wire mand_fix_t yn_i,
  input  wire mand_ctx_t load_i,
  output mand_fix_t      xnext_o,
  output mand_fix_t      ynext_o,
  output mand_ctx_t      store_o,
  output mand_fix_t      result_o
);

  localparam int ZLAT = 2 * `MAND_STAGE_LAT;  // stage 3 to stage 5 alignment

  mand_fix_t xsq;
  mand_fix_t ysq;
  mand_fix_t xy;
  mand_fix_t xmid;
  mand_fix_t xy2;
  mand_fix_t xn1;
  mand_fix_t yn1;
  mand_fix_t rx;
  mand_fix_t ry;
  mand_ctx_t tap;
  mand_fix_t xd_q [ZLAT];
  mand_fix_t yd_q [ZLAT];

  // stage 1
  mand_mult u_xsq (.clk_i, .rst_i, .a_i(xn_i), .b_i(xn_i), .p_o(xsq));
  mand_mult u_ysq (.clk_i, .rst_i, .a_i(yn_i), .b_i(yn_i), .p_o(ysq));
  mand_mult u_xy  (.clk_i, .rst_i, .a_i(xn_i), .b_i(yn_i), .p_o(xy));

  // stage 2
  mand_addsub #(.SUBTRACT(1'b1)) u_xmid (.clk_i, .rst_i, .a_i(xsq), .b_i(ysq), .s_o(xmid));
  mand_addsub #(.SUBTRACT(1'b0)) u_xy2  (.clk_i, .rst_i, .a_i(xy), .b_i(xy), .s_o(xy2)); // 2xy

  // stage 3, c comes from the context tap
  mand_addsub #(.SUBTRACT(1'b0)) u_xn1 (.clk_i, .rst_i, .a_i(tap.c_re), .b_i(xmid), .s_o(xn1));
  mand_addsub #(.SUBTRACT(1'b0)) u_yn1 (.clk_i, .rst_i, .a_i(tap.c_im), .b_i(xy2), .s_o(yn1));

  // stage 4
  mand_mult u_rx (.clk_i, .rst_i, .a_i(xn1), .b_i(xn1), .p_o(rx));
  mand_mult u_ry (.clk_i, .rst_i, .a_i(yn1), .b_i(yn1), .p_o(ry));

  // stage 5, |z|^2
  mand_addsub #(.SUBTRACT(1'b0)) u_mag (.clk_i, .rst_i, .a_i(rx), .b_i(ry), .s_o(result_o));

  mand_ctx_shift u_ctx (
    .clk_i,
    .rst_i,
    .load_i,
    .tap_o   (tap),
    .store_o
  );

  // hold z(n+1) until the magnitude is ready
  always_ff @(posedge clk_i)
  begin
    xd_q[0] <= xn1;
    yd_q[0] <= yn1;
    for (int i = 1; i < ZLAT; i++)
    begin
      xd_q[i] <= xd_q[i-1];
      yd_q[i] <= yd_q[i-1];
    end
  end

  assign xnext_o = xd_q[ZLAT-1];
  assign ynext_o = yd_q[ZLAT-1];

endmodule

`default_nettype wire

// File: logic/mand_ctx_shift.sv
`timescale 1ns/1ns
`default_nettype none
`include "mand_macros.svh"

module mand_ctx_shift
  import mand_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire mand_ctx_t load_i,
  output mand_ctx_t      tap_o,
  output mand_ctx_t      store_o
);

  localparam int DEPTH = 5 * `MAND_STAGE_LAT;
  localparam int TAP   = 2 * `MAND_STAGE_LAT - 1;  // lines up with the stage 2 outputs

  logic [DEPTH-1:0] vld_q;     // bit 0 is the newest entry
  mand_ctx_t        ctx_q [DEPTH];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      vld_q <= '0;
    else
      vld_q <= {vld_q[DEPTH-2:0], load_i.valid};
  end

  always_ff @(posedge clk_i)
  begin
    ctx_q[0] <= load_i;
    for (int i = 1; i < DEPTH; i++)
    begin
      ctx_q[i] <= ctx_q[i-1];
    end
  end

  // valid comes from the cleared chain, the rest from the payload
  always_comb
  begin
    tap_o         = ctx_q[TAP];
    tap_o.valid   = vld_q[TAP];
    store_o       = ctx_q[DEPTH-1];
    store_o.valid = vld_q[DEPTH-1];
  end

endmodule

`default_nettype wire

// File: logic/mand_addsub.sv
`timescale 1ns/1ns
`default_nettype none
`include "mand_macros.svh"

module mand_addsub
  import mand_pkg::*;
#(
  parameter bit SUBTRACT = 1'b0
)
(
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire mand_fix_t a_i,
  input  wire mand_fix_t b_i,
  output mand_fix_t      s_o
);

  localparam int LAT = `MAND_STAGE_LAT;

  mand_fix_t sum;
  mand_fix_t chain_q [LAT];

  assign sum = SUBTRACT ? (a_i - b_i) : (a_i + b_i);  // wraps on overflow

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < LAT; i++)
      begin
        chain_q[i] <= '0;
      end
    end
    else
    begin
      chain_q[0] <= sum;
      for (int i = 1; i < LAT; i++)
      begin
        chain_q[i] <= chain_q[i-1];
      end
    end
  end

  assign s_o = chain_q[LAT-1];

endmodule

`default_nettype wire

// File: logic/mand_mult.sv
`timescale 1ns/1ns
`default_nettype none
`include "mand_macros.svh"

module mand_mult
  import mand_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire mand_fix_t a_i,
  input  wire mand_fix_t b_i,
  output mand_fix_t      p_o
);

  localparam int LAT = `MAND_STAGE_LAT;

  logic signed [63:0] prod;    // full Q16.48 product
  mand_fix_t          scaled;
  mand_fix_t          chain_q [LAT];

  assign prod   = 64'(a_i) * 64'(b_i);
  assign scaled = mand_fix_t'(prod >>> `MAND_FRAC_BITS);  // back to Q8.24, top bits dropped

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < LAT; i++)
      begin
        chain_q[i] <= '0;
      end
    end
    else
    begin
      chain_q[0] <= scaled;
      for (int i = 1; i < LAT; i++)
      begin
        chain_q[i] <= chain_q[i-1];
      end
    end
  end

  assign p_o = chain_q[LAT-1];

endmodule

`default_nettype wire

// File: logic/mand_pkg.sv
`default_nettype none

package mand_pkg;

  typedef logic signed [31:0] mand_fix_t;  // Q8.24, range +-128
  typedef logic [7:0] mand_iter_t;
  typedef logic [7:0] mand_tag_t;

  // one pixel job as queued by the host
  typedef struct packed {
    mand_tag_t tag;
    mand_fix_t c_re;
    mand_fix_t c_im;
  } mand_job_t;

  // side data that rides along with each item in the pipeline
  typedef struct packed {
    logic       valid;
    logic       done;   // finished, waiting for room in the result queue
    mand_tag_t  tag;
    mand_iter_t iter;
    mand_fix_t  c_re;
    mand_fix_t  c_im;
  } mand_ctx_t;

  typedef struct packed {
    mand_tag_t  tag;
    mand_iter_t iter;
  } mand_res_t;

endpackage

`default_nettype wire

// File: logic/mand_macros.svh
`ifndef MAND_MACROS_SVH
`define MAND_MACROS_SVH

// clock cycles per pipeline stage
`define MAND_STAGE_LAT 4
`define MAND_FRAC_BITS 24

// escape radius squared, 4.0 in Q8.24
`define MAND_ESCAPE 32'sh0400_0000

`define MAND_JOBQ_DEPTH 4
`define MAND_RESQ_DEPTH 8

// word addresses on the bus
`define MAND_ADDR_CRE    3'd0
`define MAND_ADDR_CIM    3'd1
`define MAND_ADDR_PUSH   3'd2
`define MAND_ADDR_MAXIT  3'd3
`define MAND_ADDR_STATUS 3'd4
`define MAND_ADDR_RESULT 3'd5

`endif
